//--- bench/tb_rv_core.sv
module tb_rv_core;
    timeunit 1ns;
    timeprecision 1ps;

    import rv_pkg::*;

    localparam int N_BYTES      = 40;
    localparam int BYTE_TIMEOUT = 200; // cycles per byte
    localparam int HALT_TIMEOUT = 100;
    localparam int QUIET_CYCLES = 50;

    typedef struct packed {
        logic [7:0] data;
        logic [7:0] delay; // cycles until the credit goes back
    } tx_entry_t;

    logic       clk;
    logic       reset;
    logic       tx_credit;
    logic       tx_valid;
    logic [7:0] tx_data;
    logic       halted;

    tx_entry_t  expected [N_BYTES];
    int         credit_due [$]; // cycle numbers of pending returns
    integer     seed;
    int         cycle;
    int         outstanding;
    int         max_outstanding;
    int         data_errors;
    int         flow_errors;
    bit         aborted;

    rv_core u_dut (
        .clk         (clk),
        .reset       (reset),
        .i_tx_credit (tx_credit),
        .o_tx_valid  (tx_valid),
        .o_tx_data   (tx_data),
        .o_halted    (halted)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic fill_expected();
        int r;
        expected[0].data  = 8'h5d; // add  100 + -7 = 93
        expected[1].data  = 8'h6b; // sub  100 - -7 = 107
        expected[2].data  = 8'h60; // and  0x64 & 0xf9
        expected[3].data  = 8'hfd; // or   0x64 | 0xf9
        expected[4].data  = 8'h9d; // xor  0x64 ^ 0xf9
        expected[5].data  = 8'h20; // sll  100 << 3 = 0x320
        expected[6].data  = 8'h0f; // srl  0xfffffff9 >> 28
        expected[7].data  = 8'hff; // sra  -7 >>> 28 = -1
        expected[8].data  = 8'h9c; // addi 100 + -200 = -100
        expected[9].data  = 8'hf0; // andi -7 & -16
        expected[10].data = 8'h67; // ori  0x64 | 0xffffff03
        expected[11].data = 8'h9b; // xori 100 ^ -1
        expected[12].data = 8'h80; // slli 100 << 5 = 0xc80
        expected[13].data = 8'h07; // srli 0xfffffff9 >> 29
        expected[14].data = 8'hfc; // srai -7 >>> 1 = -4
        expected[15].data = 8'h01; // slt  -7 < 100
        expected[16].data = 8'h00; // sltu 0xfffffff9 < 100 is false
        expected[17].data = 8'h01; // slti -7 < -6
        expected[18].data = 8'h01; // sltiu 100 < 0xffffffff
        expected[19].data = 8'h00; // byte 0 of lui 0xabcde000
        expected[20].data = 8'he0;
        expected[21].data = 8'hcd;
        expected[22].data = 8'hab;
        expected[23].data = 8'hd4; // auipc 0xd4 + 0x12000 = 0x120d4
        expected[24].data = 8'h20;
        expected[25].data = 8'h01;
        expected[26].data = 8'h31; // beq pair gives marker 0x30 + 1
        expected[27].data = 8'h32; // bne
        expected[28].data = 8'h33; // blt
        expected[29].data = 8'h34; // bge
        expected[30].data = 8'h35; // bltu
        expected[31].data = 8'h36; // bgeu
        expected[32].data = 8'h68; // jal link 0x164 + 4
        expected[33].data = 8'h37; // marker after jalr return
        expected[34].data = 8'h78; // byte 0 of lw 0x12345678
        expected[35].data = 8'h12; // byte 3
        expected[36].data = 8'h64; // sb 0x64 to byte 2 gives 0x12645678
        expected[37].data = 8'h78;
        expected[38].data = 8'h56;
        expected[39].data = 8'h00; // x0 after addi x0
        for (int k = 0; k < N_BYTES; k++) begin
            r = $random(seed);
            if (k % 8 >= 4) begin
                expected[k].delay = 8'(16 + (r & 15)); // long delay drains credits
            end else begin
                expected[k].delay = 8'(1 + (r & 3));
            end
        end
    endtask

    // sample the port and drive the credit line on each falling edge
    task automatic run_cycle(output bit got);
        @(negedge clk);
        cycle++;
        got = (tx_valid === 1'b1);
        if (got) begin
            outstanding++;
            if (outstanding > max_outstanding) begin
                max_outstanding = outstanding;
            end
            assert (outstanding <= TX_CREDITS) else begin
                flow_errors++;
                $display("Error: %0t: %0d bytes outstanding, limit %0d",
                         $time, outstanding, TX_CREDITS);
            end
        end
        if (credit_due.size() > 0 && credit_due[0] <= cycle) begin
            credit_due.delete(0);
            outstanding--;
            tx_credit   = 1'b1;
        end else begin
            tx_credit = 1'b0;
        end
    endtask

    task automatic schedule_credit(input int delay);
        int due;
        due = cycle + delay;
        if (credit_due.size() > 0 && due <= credit_due[$]) begin
            due = credit_due[$] + 1; // one return per cycle
        end
        credit_due.push_back(due);
    endtask

    initial begin
        int k;
        int waited;
        bit got;
        seed            = 8044;
        reset           = 1'b1;
        tx_credit       = 1'b0;
        cycle           = 0;
        outstanding     = 0;
        max_outstanding = 0;
        data_errors     = 0;
        flow_errors     = 0;
        aborted         = 1'b0;
        fill_expected();

        repeat (10) @(negedge clk);
        assert (tx_valid === 1'b0 && halted === 1'b0) else begin
            flow_errors++;
            $display("Error: %0t: tx_valid or halted not low in reset", $time);
        end
        reset = 1'b0;

        k = 0;
        while (k < N_BYTES && !aborted) begin
            waited = 0;
            got    = 1'b0;
            while (!got && !aborted) begin
                run_cycle(got);
                waited++;
                if (!got && halted === 1'b1) begin
                    $display("Core halted at %0t with byte %0d still missing", $time, k);
                    aborted = 1'b1;
                end else if (!got && waited >= BYTE_TIMEOUT) begin
                    $display("Timed out at %0t waiting for byte %0d", $time, k);
                    aborted = 1'b1;
                end
            end
            if (got) begin
                assert (tx_data === expected[k].data) else begin
                    data_errors++;
                    $display("Error: %0t: byte %0d is %h, expected %h",
                             $time, k, tx_data, expected[k].data);
                end
                schedule_credit(expected[k].delay);
                k++;
            end
        end

        waited = 0;
        while (!aborted && halted !== 1'b1) begin
            run_cycle(got);
            waited++;
            assert (!got) else begin
                flow_errors++;
                $display("Error: %0t: extra byte %h before halt", $time, tx_data);
            end
            if (halted !== 1'b1 && waited >= HALT_TIMEOUT) begin
                $display("Timed out at %0t waiting for the core to halt", $time);
                aborted = 1'b1;
            end
        end

        if (!aborted) begin
            repeat (QUIET_CYCLES) begin
                run_cycle(got);
                assert (!got && halted === 1'b1) else begin
                    flow_errors++;
                    $display("Error: %0t: activity after halt, byte %h", $time, tx_data);
                end
            end
            assert (max_outstanding == TX_CREDITS) else begin
                flow_errors++;
                $display("Error: %0t: credits never ran out, peak %0d outstanding",
                         $time, max_outstanding);
            end
        end

        $display("%0d data errors, %0d flow errors", data_errors, flow_errors);
        if (aborted || data_errors != 0 || flow_errors != 0) begin
            $display("Regression failed");
        end else begin
            $display("Regression passed");
        end
        $finish;
    end

endmodule

//--- design/rv_control_fsm.sv
module rv_control_fsm (
    input  logic clk,
    input  logic reset,
    input  logic i_is_tx_store,
    input  logic i_is_halt,
    input  logic i_has_credit,
    output logic o_commit,
    output logic o_tx_fire,
    output logic o_halted
);

    typedef enum logic [1:0] {
        RUN,
        WAIT_CREDIT,
        HALTED
    } state_e;

    state_e state;
    state_e state_next;
    logic   starved;

    assign starved = i_is_tx_store && !i_has_credit;

    always_comb begin
        state_next = state;
        o_commit   = 1'b0;
        case (state)
            RUN: begin
                if (i_is_halt) begin
                    state_next = HALTED;
                end else if (starved) begin
                    state_next = WAIT_CREDIT; // hold pc on the store
                end else begin
                    o_commit = 1'b1;
                end
            end
            WAIT_CREDIT: begin
                if (i_has_credit) begin
                    state_next = RUN;
                end
            end
            default: state_next = HALTED; // only reset leaves
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= RUN;
        end else begin
            state <= state_next;
        end
    end

    assign o_tx_fire = o_commit && i_is_tx_store;
    assign o_halted  = (state == HALTED);

endmodule

//--- design/rv_core.sv
module rv_core (
    input  logic       clk,
    input  logic       reset,
    input  logic       i_tx_credit,
    output logic       o_tx_valid,
    output logic [7:0] o_tx_data,
    output logic       o_halted
);
    import rv_pkg::*;

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] inst;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] wb_data;
    logic [XLEN-1:0] next_pc;
    logic [XLEN-1:0] load_data;
    dec_t            dec;
    mem_req_t        mem_req;
    logic            is_tx_store;
    logic            is_halt;
    logic            commit;
    logic            tx_fire;
    logic            has_credit;
    logic            arch_we;

    assign arch_we = commit && !reset; // no memory writes while reset held

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (commit) begin
            pc <= next_pc;
        end
    end

    rv_imem u_imem (
        .i_addr (pc),
        .o_inst (inst)
    );

    rv_decoder u_decoder (
        .i_inst (inst),
        .o_dec  (dec)
    );

    rv_regfile u_regfile (
        .clk        (clk),
        .i_rs1      (dec.rs1),
        .i_rs2      (dec.rs2),
        .i_we       (arch_we && dec.wb_en),
        .i_rd       (dec.rd),
        .i_wdata    (wb_data),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    rv_exec u_exec (
        .i_dec         (dec),
        .i_pc          (pc),
        .i_rs1_data    (rs1_data),
        .i_rs2_data    (rs2_data),
        .i_load_data   (load_data),
        .o_wb_data     (wb_data),
        .o_next_pc     (next_pc),
        .o_mem_req     (mem_req),
        .o_is_tx_store (is_tx_store),
        .o_is_halt     (is_halt),
        .o_tx_data     (o_tx_data)
    );

    rv_dmem u_dmem (
        .clk     (clk),
        .i_req   (mem_req),
        .i_we    (arch_we),
        .o_rdata (load_data)
    );

    rv_control_fsm u_control_fsm (
        .clk           (clk),
        .reset         (reset),
        .i_is_tx_store (is_tx_store),
        .i_is_halt     (is_halt),
        .i_has_credit  (has_credit),
        .o_commit      (commit),
        .o_tx_fire     (tx_fire),
        .o_halted      (o_halted)
    );

    rv_tx_credit u_tx_credit (
        .clk          (clk),
        .reset        (reset),
        .i_tx_fire    (tx_fire),
        .i_tx_credit  (i_tx_credit),
        .o_has_credit (has_credit)
    );

    assign o_tx_valid = tx_fire;

endmodule

//--- design/rv_decoder.sv
module rv_decoder (
    input  logic [rv_pkg::XLEN-1:0] i_inst,
    output rv_pkg::dec_t            o_dec
);
    import rv_pkg::*;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;

    assign opcode = i_inst[6:0];
    assign funct3 = i_inst[14:12];
    assign funct7 = i_inst[31:25];

    assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
    assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
    assign imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
    assign imm_u = {i_inst[31:12], 12'h000};
    assign imm_j = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

    always_comb begin
        o_dec         = '0;
        o_dec.op      = OP_ILLEGAL;
        o_dec.rd      = i_inst[11:7];
        o_dec.rs1     = i_inst[19:15];
        o_dec.rs2     = i_inst[24:20];
        case (opcode)
            OPC_LUI: begin
                o_dec.op  = OP_LUI;
                o_dec.imm = imm_u;
            end
            OPC_AUIPC: begin
                o_dec.op  = OP_AUIPC;
                o_dec.imm = imm_u;
            end
            OPC_JAL: begin
                o_dec.op  = OP_JAL;
                o_dec.imm = imm_j;
            end
            OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    o_dec.op = OP_JALR;
                end
                o_dec.imm     = imm_i;
                o_dec.use_imm = 1'b1;
            end
            OPC_BRANCH: begin
                case (funct3)
                    3'b000:  o_dec.op = OP_BEQ;
                    3'b001:  o_dec.op = OP_BNE;
                    3'b100:  o_dec.op = OP_BLT;
                    3'b101:  o_dec.op = OP_BGE;
                    3'b110:  o_dec.op = OP_BLTU;
                    3'b111:  o_dec.op = OP_BGEU;
                    default: o_dec.op = OP_ILLEGAL;
                endcase
                o_dec.imm = imm_b; // compare uses rs2, not imm
            end
            OPC_LOAD: begin
                if (funct3 == 3'b010) begin
                    o_dec.op = OP_LW;
                end
                o_dec.imm     = imm_i;
                o_dec.use_imm = 1'b1;
            end
            OPC_STORE: begin
                case (funct3)
                    3'b000:  o_dec.op = OP_SB;
                    3'b010:  o_dec.op = OP_SW;
                    default: o_dec.op = OP_ILLEGAL;
                endcase
                o_dec.imm     = imm_s;
                o_dec.use_imm = 1'b1;
            end
            OPC_OPIMM: begin
                case (funct3)
                    3'b000:  o_dec.op = OP_ADD;
                    3'b010:  o_dec.op = OP_SLT;
                    3'b011:  o_dec.op = OP_SLTU;
                    3'b100:  o_dec.op = OP_XOR;
                    3'b110:  o_dec.op = OP_OR;
                    3'b111:  o_dec.op = OP_AND;
                    3'b001:  o_dec.op = (funct7 == 7'h00) ? OP_SLL : OP_ILLEGAL;
                    default: begin
                        if (funct7 == 7'h00) begin
                            o_dec.op = OP_SRL;
                        end else if (funct7 == 7'h20) begin
                            o_dec.op = OP_SRA;
                        end
                    end
                endcase
                o_dec.imm     = imm_i; // shamt sits in imm[4:0]
                o_dec.use_imm = 1'b1;
            end
            OPC_OP: begin
                case ({funct7, funct3})
                    {7'h00, 3'b000}: o_dec.op = OP_ADD;
                    {7'h20, 3'b000}: o_dec.op = OP_SUB;
                    {7'h00, 3'b001}: o_dec.op = OP_SLL;
                    {7'h00, 3'b010}: o_dec.op = OP_SLT;
                    {7'h00, 3'b011}: o_dec.op = OP_SLTU;
                    {7'h00, 3'b100}: o_dec.op = OP_XOR;
                    {7'h00, 3'b101}: o_dec.op = OP_SRL;
                    {7'h20, 3'b101}: o_dec.op = OP_SRA;
                    {7'h00, 3'b110}: o_dec.op = OP_OR;
                    {7'h00, 3'b111}: o_dec.op = OP_AND;
                    default:         o_dec.op = OP_ILLEGAL;
                endcase
            end
            OPC_SYSTEM: begin
                if (i_inst == 32'h0010_0073) begin
                    o_dec.op = OP_EBREAK;
                end
            end
            default: o_dec.op = OP_ILLEGAL;
        endcase
        o_dec.wb_en = !(o_dec.op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
                                         OP_SW, OP_SB, OP_EBREAK, OP_ILLEGAL});
    end

endmodule

//--- design/rv_dmem.sv
module rv_dmem (
    input  logic                    clk,
    input  rv_pkg::mem_req_t        i_req,
    input  logic                    i_we,
    output logic [rv_pkg::XLEN-1:0] o_rdata
);
    import rv_pkg::*;

    logic [XLEN-1:0] mem [DMEM_WORDS];

    always_ff @(posedge clk) begin
        if (i_we) begin
            for (int b = 0; b < 4; b++) begin
                if (i_req.byte_en[b]) begin
                    mem[i_req.word_addr][8*b +: 8] <= i_req.wdata[8*b +: 8];
                end
            end
        end
    end

    assign o_rdata = mem[i_req.word_addr]; // async word read

endmodule

//--- design/rv_exec.sv
module rv_exec (
    input  rv_pkg::dec_t            i_dec,
    input  logic [rv_pkg::XLEN-1:0] i_pc,
    input  logic [rv_pkg::XLEN-1:0] i_rs1_data,
    input  logic [rv_pkg::XLEN-1:0] i_rs2_data,
    input  logic [rv_pkg::XLEN-1:0] i_load_data,
    output logic [rv_pkg::XLEN-1:0] o_wb_data,
    output logic [rv_pkg::XLEN-1:0] o_next_pc,
    output rv_pkg::mem_req_t        o_mem_req,
    output logic                    o_is_tx_store,
    output logic                    o_is_halt,
    output logic [7:0]              o_tx_data
);
    import rv_pkg::*;

    logic [XLEN-1:0] opb;
    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] pc_imm;
    logic [XLEN-1:0] alu_res;
    logic            taken;

    assign opb      = i_dec.use_imm ? i_dec.imm : i_rs2_data;
    assign sum      = i_rs1_data + opb; // also the load/store address
    assign pc_plus4 = i_pc + 32'd4;
    assign pc_imm   = i_pc + i_dec.imm;

    always_comb begin
        case (i_dec.op)
            OP_SUB:   alu_res = i_rs1_data - opb;
            OP_AND:   alu_res = i_rs1_data & opb;
            OP_OR:    alu_res = i_rs1_data | opb;
            OP_XOR:   alu_res = i_rs1_data ^ opb;
            OP_SLL:   alu_res = i_rs1_data << opb[4:0];
            OP_SRL:   alu_res = i_rs1_data >> opb[4:0];
            OP_SRA:   alu_res = $signed(i_rs1_data) >>> opb[4:0];
            OP_SLT:   alu_res = XLEN'($signed(i_rs1_data) < $signed(opb));
            OP_SLTU:  alu_res = XLEN'(i_rs1_data < opb);
            OP_LUI:   alu_res = i_dec.imm;
            OP_AUIPC: alu_res = pc_imm;
            OP_JAL,
            OP_JALR:  alu_res = pc_plus4; // link value
            default:  alu_res = sum;
        endcase
    end

    always_comb begin
        case (i_dec.op)
            OP_BEQ:  taken = (i_rs1_data == i_rs2_data);
            OP_BNE:  taken = (i_rs1_data != i_rs2_data);
            OP_BLT:  taken = ($signed(i_rs1_data) < $signed(i_rs2_data));
            OP_BGE:  taken = ($signed(i_rs1_data) >= $signed(i_rs2_data));
            OP_BLTU: taken = (i_rs1_data < i_rs2_data);
            OP_BGEU: taken = (i_rs1_data >= i_rs2_data);
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        if (i_dec.op == OP_JALR) begin
            o_next_pc = {sum[XLEN-1:1], 1'b0};
        end else if (i_dec.op == OP_JAL || taken) begin
            o_next_pc = pc_imm;
        end else begin
            o_next_pc = pc_plus4;
        end
    end

    assign o_is_tx_store = (i_dec.op == OP_SB) && (sum == TX_ADDR);
    assign o_is_halt     = (i_dec.op == OP_EBREAK);
    assign o_tx_data     = i_rs2_data[7:0];
    assign o_wb_data     = (i_dec.op == OP_LW) ? i_load_data : alu_res;

    always_comb begin
        o_mem_req.word_addr = sum[DMEM_AW+1:2];
        o_mem_req.wdata     = (i_dec.op == OP_SB) ? {4{i_rs2_data[7:0]}} : i_rs2_data;
        o_mem_req.byte_en   = 4'b0000;
        if (i_dec.op == OP_SW) begin
            o_mem_req.byte_en = 4'b1111;
        end else if (i_dec.op == OP_SB && !o_is_tx_store) begin
            o_mem_req.byte_en = 4'b0001 << sum[1:0]; // lane from low address bits
        end
    end

    // program must stay within the kept instruction set once pc is valid
    illegal_op_a: assert final ($isunknown(i_pc) || i_dec.op != OP_ILLEGAL)
        else $error("illegal instruction at pc %h", i_pc);

endmodule

//--- design/rv_imem.sv
module rv_imem (
    input  logic [rv_pkg::XLEN-1:0] i_addr,
    output logic [rv_pkg::XLEN-1:0] o_inst
);
    import rv_pkg::*;

    logic [XLEN-1:0] rom [IMEM_WORDS];

    initial begin
        $readmemh("program.hex", rom);
    end

    assign o_inst = rom[i_addr[IMEM_AW+1:2]]; // word index

    // a misaligned pc can only come from a bad jalr or branch target
    pc_aligned_a: assert final ($isunknown(i_addr) || i_addr[1:0] == 2'b00)
        else $error("misaligned fetch at %h", i_addr);

endmodule

//--- design/rv_pkg.sv
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int IMEM_WORDS = 256;
    localparam int DMEM_WORDS = 256;
    localparam int IMEM_AW    = $clog2(IMEM_WORDS);
    localparam int DMEM_AW    = $clog2(DMEM_WORDS);

    localparam logic [XLEN-1:0] TX_ADDR = 32'h0002_0020; // store-mapped tx port
    localparam int TX_CREDITS = 4;
    localparam int CREDIT_W   = 3;

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    typedef enum logic [4:0] {
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
        OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU,
        OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_LW, OP_SW, OP_SB, OP_EBREAK, OP_ILLEGAL
    } alu_op_e;

    typedef struct packed {
        alu_op_e               op;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [XLEN-1:0]       imm;     // already sign extended
        logic                  use_imm; // operand b from imm
        logic                  wb_en;
    } dec_t;

    typedef struct packed {
        logic [DMEM_AW-1:0] word_addr;
        logic [XLEN-1:0]    wdata;
        logic [3:0]         byte_en; // all zero means no write
    } mem_req_t;

endpackage

//--- design/rv_regfile.sv
module rv_regfile (
    input  logic                          clk,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_rs1,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_rs2,
    input  logic                          i_we,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_rd,
    input  logic [rv_pkg::XLEN-1:0]       i_wdata,
    output logic [rv_pkg::XLEN-1:0]       o_rs1_data,
    output logic [rv_pkg::XLEN-1:0]       o_rs2_data
);
    import rv_pkg::*;

    logic [XLEN-1:0] regs [1:31]; // x0 has no storage

    always_ff @(posedge clk) begin
        if (i_we && i_rd != '0) begin
            regs[i_rd] <= i_wdata;
        end
    end

    assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
    assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

//--- design/rv_tx_credit.sv
module rv_tx_credit (
    input  logic clk,
    input  logic reset,
    input  logic i_tx_fire,
    input  logic i_tx_credit,
    output logic o_has_credit
);
    import rv_pkg::*;

    logic [CREDIT_W-1:0] count;

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= CREDIT_W'(TX_CREDITS);
        end else if (i_tx_fire && !i_tx_credit) begin
            count <= count - 1'b1;
        end else if (i_tx_credit && !i_tx_fire) begin
            count <= count + 1'b1;
        end
    end

    assign o_has_credit = (count != '0);

    // sink returns no more than it was sent
    max_credit_a: assert property (@(posedge clk) disable iff (reset)
        count <= CREDIT_W'(TX_CREDITS));

    no_underflow_a: assert property (@(posedge clk) disable iff (reset)
        i_tx_fire |-> count != '0);

endmodule

//--- program.hex
// one RV32I instruction word per line, starting at byte address 0
// x10 = tx base, x1 = 100, x2 = -7, x11 = 28, x12 = 3, x14 = bad marker, x15 = marker count
00020537 // 000 lui   x10, 0x20
06400093 // 004 addi  x1, x0, 100
FF900113 // 008 addi  x2, x0, -7
01C00593 // 00c addi  x11, x0, 28
00300613 // 010 addi  x12, x0, 3
0EE00713 // 014 addi  x14, x0, 0xee
03000793 // 018 addi  x15, x0, 0x30
002081B3 // 01c add   x3, x1, x2
02350023 // 020 sb    x3, 0x20(x10)
402081B3 // 024 sub   x3, x1, x2
02350023 // 028 sb    x3
0020F1B3 // 02c and   x3, x1, x2
02350023 // 030 sb    x3
0020E1B3 // 034 or    x3, x1, x2
02350023 // 038 sb    x3
0020C1B3 // 03c xor   x3, x1, x2
02350023 // 040 sb    x3
00C091B3 // 044 sll   x3, x1, x12
02350023 // 048 sb    x3
00B151B3 // 04c srl   x3, x2, x11
02350023 // 050 sb    x3
40B151B3 // 054 sra   x3, x2, x11
02350023 // 058 sb    x3
F3808193 // 05c addi  x3, x1, -200
02350023 // 060 sb    x3
FF017193 // 064 andi  x3, x2, -16
02350023 // 068 sb    x3
F030E193 // 06c ori   x3, x1, -253
02350023 // 070 sb    x3
FFF0C193 // 074 xori  x3, x1, -1
02350023 // 078 sb    x3
00509193 // 07c slli  x3, x1, 5
02350023 // 080 sb    x3
01D15193 // 084 srli  x3, x2, 29
02350023 // 088 sb    x3
40115193 // 08c srai  x3, x2, 1
02350023 // 090 sb    x3
001121B3 // 094 slt   x3, x2, x1
02350023 // 098 sb    x3
001131B3 // 09c sltu  x3, x2, x1
02350023 // 0a0 sb    x3
FFA12193 // 0a4 slti  x3, x2, -6
02350023 // 0a8 sb    x3
FFF0B193 // 0ac sltiu x3, x1, -1
02350023 // 0b0 sb    x3
ABCDE237 // 0b4 lui   x4, 0xabcde
02450023 // 0b8 sb    x4
00825193 // 0bc srli  x3, x4, 8
02350023 // 0c0 sb    x3
01025193 // 0c4 srli  x3, x4, 16
02350023 // 0c8 sb    x3
01825193 // 0cc srli  x3, x4, 24
02350023 // 0d0 sb    x3
00012317 // 0d4 auipc x6, 0x12
02650023 // 0d8 sb    x6
00835193 // 0dc srli  x3, x6, 8
02350023 // 0e0 sb    x3
01035193 // 0e4 srli  x3, x6, 16
02350023 // 0e8 sb    x3
00108463 // 0ec beq   x1, x1, +8
02E50023 // 0f0 sb    x14
00208463 // 0f4 beq   x1, x2, +8
00178793 // 0f8 addi  x15, x15, 1
02F50023 // 0fc sb    x15
00209463 // 100 bne   x1, x2, +8
02E50023 // 104 sb    x14
00109463 // 108 bne   x1, x1, +8
00178793 // 10c addi  x15, x15, 1
02F50023 // 110 sb    x15
00114463 // 114 blt   x2, x1, +8
02E50023 // 118 sb    x14
0020C463 // 11c blt   x1, x2, +8
00178793 // 120 addi  x15, x15, 1
02F50023 // 124 sb    x15
0020D463 // 128 bge   x1, x2, +8
02E50023 // 12c sb    x14
00115463 // 130 bge   x2, x1, +8
00178793 // 134 addi  x15, x15, 1
02F50023 // 138 sb    x15
0020E463 // 13c bltu  x1, x2, +8
02E50023 // 140 sb    x14
00116463 // 144 bltu  x2, x1, +8
00178793 // 148 addi  x15, x15, 1
02F50023 // 14c sb    x15
00117463 // 150 bgeu  x2, x1, +8
02E50023 // 154 sb    x14
0020F463 // 158 bgeu  x1, x2, +8
00178793 // 15c addi  x15, x15, 1
02F50023 // 160 sb    x15
010002EF // 164 jal   x5, +16
00178793 // 168 addi  x15, x15, 1
02F50023 // 16c sb    x15
00C0006F // 170 jal   x0, +12
02550023 // 174 sb    x5
00128067 // 178 jalr  x0, 1(x5)
04000A13 // 17c addi  x20, x0, 64
12345B37 // 180 lui   x22, 0x12345
678B0B13 // 184 addi  x22, x22, 0x678
016A2023 // 188 sw    x22, 0(x20)
000A2A83 // 18c lw    x21, 0(x20)
03550023 // 190 sb    x21
018AD193 // 194 srli  x3, x21, 24
02350023 // 198 sb    x3
001A0123 // 19c sb    x1, 2(x20)
000A2A83 // 1a0 lw    x21, 0(x20)
010AD193 // 1a4 srli  x3, x21, 16
02350023 // 1a8 sb    x3
03550023 // 1ac sb    x21
008AD193 // 1b0 srli  x3, x21, 8
02350023 // 1b4 sb    x3
00508013 // 1b8 addi  x0, x1, 5
02050023 // 1bc sb    x0
00100073 // 1c0 ebreak

//--- sim.f
design/rv_pkg.sv
design/rv_imem.sv
design/rv_decoder.sv
design/rv_exec.sv
design/rv_regfile.sv
design/rv_dmem.sv
design/rv_control_fsm.sv
design/rv_tx_credit.sv
design/rv_core.sv
bench/tb_rv_core.sv
